// File: led_locator.f
verilog/led_locator_pkg.sv
verilog/video_timing.sv
verilog/chroma_threshold.sv
verilog/pipe_delay.sv
verilog/centroid_accum.sv
verilog/calib_step_ctrl.sv
verilog/overlay_mux.sv
verilog/led_locator_top.sv
tb/tb_led_locator.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it and grade the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_led_locator \
    -f led_locator.f -o sim_led_locator > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_led_locator > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -qx "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tb/tb_led_locator.sv
`timescale 1ns/1ps

module tb_led_locator
    import led_locator_pkg::*;
();

    // small frame, 64x48 active inside 80x52
    localparam int H_ACTIVE    = 64;
    localparam int H_FRONT     = 4;
    localparam int H_SYNC      = 8;
    localparam int H_TOTAL     = 80;
    localparam int V_ACTIVE    = 48;
    localparam int V_FRONT     = 1;
    localparam int V_SYNC      = 2;
    localparam int V_TOTAL     = 52;
    localparam int WAIT_FRAMES = 2;

    localparam int CLK_PERIOD   = 20;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    // frames per test: reset, mask view, tracking, hit, miss
    localparam int TEST_FRAMES  = 2 + 3 + 4 + 5 + 7;
    localparam int WATCHDOG_NS  = 3 * TEST_FRAMES * FRAME_CYCLES * CLK_PERIOD;
    // strobe to done spans the wait frames, the measured frame and the division
    localparam int CALIB_LIMIT  = (WAIT_FRAMES + 3) * FRAME_CYCLES;

    logic    clk_pixel = 1'b0;
    logic    sys_rst_pixel;
    chroma_t cr_in;
    chroma_t cb_in;
    chroma_t thresh_lower;
    logic    display_sel;
    logic    crosshair_en;
    logic    calib_start;
    hcount_t video_hcount;
    vcount_t video_vcount;
    logic    video_active;
    chroma_t out_red;
    chroma_t out_green;
    chroma_t out_blue;
    logic    out_hsync;
    logic    out_vsync;
    logic    out_active;
    logic    calib_busy;
    logic    calib_done;
    logic    calib_hit;
    hcount_t calib_x;
    vcount_t calib_y;

    // scene, a rectangle on a flat background or a coordinate pattern
    logic    pattern_on = 1'b0;
    int      salt       = 0;
    int      rect_x0    = 0;
    int      rect_y0    = 0;
    int      rect_w     = 0;
    int      rect_h     = 0;
    chroma_t fg_cr      = '0;
    chroma_t fg_cb      = '0;
    chroma_t bg_cr      = '0;
    chroma_t bg_cb      = '0;
    // crosshair position the DUT is expected to hold
    hcount_t exp_track_x = '0;
    vcount_t exp_track_y = '0;
    // pixel compare enable and the stage 0 coordinate history
    logic    video_check = 1'b0;
    hcount_t h_d1 = '0;
    hcount_t h_d2 = '0;
    vcount_t v_d1 = '0;
    vcount_t v_d2 = '0;
    string   test_name    = "";
    int      test_errors  = 0;
    int      tests_passed = 0;
    int      tests_failed = 0;
    int unsigned seed_val;

    always #(CLK_PERIOD / 2) clk_pixel = ~clk_pixel;

    led_locator_top #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_TOTAL(H_TOTAL),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_TOTAL(V_TOTAL),
        .WAIT_FRAMES(WAIT_FRAMES)
    ) UUT (
        .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel),
        .cr_in(cr_in), .cb_in(cb_in), .thresh_lower(thresh_lower),
        .display_sel(display_sel), .crosshair_en(crosshair_en), .calib_start(calib_start),
        .video_hcount(video_hcount), .video_vcount(video_vcount), .video_active(video_active),
        .out_red(out_red), .out_green(out_green), .out_blue(out_blue),
        .out_hsync(out_hsync), .out_vsync(out_vsync), .out_active(out_active),
        .calib_busy(calib_busy), .calib_done(calib_done), .calib_hit(calib_hit),
        .calib_x(calib_x), .calib_y(calib_y)
    );

    function automatic int rand_between(input int lo, input int hi);
        return lo + int'($urandom % unsigned'(hi - lo + 1));
    endfunction

    function automatic logic in_rect(input int h, input int v);
        return (h >= rect_x0) && (h < rect_x0 + rect_w) &&
               (v >= rect_y0) && (v < rect_y0 + rect_h);
    endfunction

    function automatic chroma_t scene_cr(input int h, input int v);
        if (pattern_on) return chroma_t'(h * 37 + v * 11 + salt);
        return in_rect(h, v) ? fg_cr : bg_cr;
    endfunction

    function automatic chroma_t scene_cb(input int h, input int v);
        if (pattern_on) return chroma_t'((h * 13) ^ (v * 29 + salt * 3));
        return in_rect(h, v) ? fg_cb : bg_cb;
    endfunction

    // floor of the mean over active pixels whose cb reaches the threshold
    function automatic logic ref_centroid(output hcount_t cx, output vcount_t cy);
        longint sx;
        longint sy;
        longint n;
        sx = 0;
        sy = 0;
        n  = 0;
        for (int v = 0; v < V_ACTIVE; v++) begin
            for (int h = 0; h < H_ACTIVE; h++) begin
                if (scene_cb(h, v) >= thresh_lower) begin
                    sx += h;
                    sy += v;
                    n++;
                end
            end
        end
        cx = (n == 0) ? '0 : hcount_t'(sx / n);
        cy = (n == 0) ? '0 : vcount_t'(sy / n);
        return n != 0;
    endfunction

    // raster order, the coordinate that follows (h, v) in the frame
    function automatic void next_pixel(input hcount_t h, input vcount_t v,
                                       output hcount_t nh, output vcount_t nv);
        nv = v;
        if (int'(h) == H_TOTAL - 1) begin
            nh = '0;
            if (int'(v) == V_TOTAL - 1) begin
                nv = '0;
            end else begin
                nv = v + 1'b1;
            end
        end else begin
            nh = h + 1'b1;
        end
    endfunction

    // overlay rule for one stage 0 pixel
    function automatic void expect_color(input int h, input int v,
                                         output chroma_t r, output chroma_t g,
                                         output chroma_t b);
        logic det_r;
        logic det_b;
        det_r = scene_cr(h, v) >= thresh_lower;
        det_b = scene_cb(h, v) >= thresh_lower;
        r = '0;
        g = '0;
        b = '0;
        if (h >= H_ACTIVE || v >= V_ACTIVE) return;
        if (crosshair_en && (h == int'(exp_track_x) || v == int'(exp_track_y))) begin
            r = '1;
            g = '1;
            b = '1;
        end else if (!display_sel) begin
            r = scene_cr(h, v);
            b = scene_cb(h, v);
        end else if (det_b) begin
            r = '1;
            g = '1;
            b = '1;
        end else if (det_r) begin
            // magenta
            r = '1;
            b = '1;
        end
    endfunction

    task automatic check_color(input string what, input chroma_t expected, input chroma_t actual);
        if (expected !== actual) begin
            $display("Error %s: expected %0d, actual %0d", what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_coord(input string what, input hcount_t exp_x, input vcount_t exp_y,
                               input hcount_t act_x, input vcount_t act_y);
        if (exp_x !== act_x || exp_y !== act_y) begin
            $display("Error %s: expected (%0d,%0d), actual (%0d,%0d)",
                     what, exp_x, exp_y, act_x, act_y);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("Error %s: expected %0b, actual %0b", what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic compare_pixel(input hcount_t hc, input vcount_t vc);
        chroma_t er;
        chroma_t eg;
        chroma_t eb;
        int      h;
        int      v;
        string   where;
        h     = int'(hc);
        v     = int'(vc);
        where = $sformatf("%s pixel (%0d,%0d)", test_name, h, v);
        expect_color(h, v, er, eg, eb);
        check_color({where, " red"}, er, out_red);
        check_color({where, " green"}, eg, out_green);
        check_color({where, " blue"}, eb, out_blue);
        check_flag({where, " hsync"},
                   h >= H_ACTIVE + H_FRONT && h < H_ACTIVE + H_FRONT + H_SYNC, out_hsync);
        check_flag({where, " vsync"},
                   v >= V_ACTIVE + V_FRONT && v < V_ACTIVE + V_FRONT + V_SYNC, out_vsync);
        check_flag({where, " active"}, h < H_ACTIVE && v < V_ACTIVE, out_active);
    endtask

    // returns 1 ns after the edge that presents pixel (0,0)
    task automatic wait_frame_start();
        do begin
            @(posedge clk_pixel);
            #1;
        end while (video_hcount != '0 || video_vcount != '0);
    endtask

    // cb rectangle above thr on a background below it, cr stays below
    task automatic place_rect(input int thr);
        pattern_on = 1'b0;
        rect_x0    = rand_between(0, H_ACTIVE - 8);
        rect_y0    = rand_between(0, V_ACTIVE - 8);
        rect_w     = rand_between(1, 8);
        rect_h     = rand_between(1, 8);
        fg_cr      = chroma_t'(rand_between(0, thr - 1));
        fg_cb      = chroma_t'(rand_between(thr, 255));
        bg_cr      = chroma_t'(rand_between(0, thr - 1));
        bg_cb      = chroma_t'(rand_between(0, thr - 1));
    endtask

    // strobe, then poll each cycle for done, busy must hold meanwhile
    task automatic run_calibration(input logic exp_hit, input hcount_t exp_x,
                                   input vcount_t exp_y);
        int waited;
        waited = 0;
        @(posedge clk_pixel);
        #2;
        calib_start = 1'b1;
        @(posedge clk_pixel);
        #2;
        calib_start = 1'b0;
        while (!calib_done && waited < CALIB_LIMIT) begin
            check_flag({test_name, " calib_busy"}, 1'b1, calib_busy);
            @(posedge clk_pixel);
            #2;
            waited++;
        end
        if (!calib_done) begin
            $display("%s: calib_done did not arrive within %0d cycles", test_name, CALIB_LIMIT);
            test_errors++;
        end else begin
            check_flag({test_name, " calib_hit"}, exp_hit, calib_hit);
            check_coord({test_name, " calib position"}, exp_x, exp_y, calib_x, calib_y);
            check_flag({test_name, " calib_busy at done"}, 1'b0, calib_busy);
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("%s: pass", test_name);
            tests_passed++;
        end else begin
            $display("%s: FAIL with %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    // pixel stimulus, cr/cb for the coordinate the DUT just presented
    initial begin
        cr_in = '0;
        cb_in = '0;
        forever begin
            @(posedge clk_pixel);
            #2;
            cr_in = scene_cr(int'(video_hcount), int'(video_vcount));
            cb_in = scene_cb(int'(video_hcount), int'(video_vcount));
        end
    end

    // output compare, outputs belong to the coordinate seen two cycles earlier
    initial begin
        hcount_t next_h;
        vcount_t next_v;
        forever begin
            @(posedge clk_pixel);
            #5;
            if (video_check) begin
                compare_pixel(h_d2, v_d2);
                // stage 0 coordinate steps through the raster one pixel per cycle
                next_pixel(h_d1, v_d1, next_h, next_v);
                check_coord({test_name, " video coordinate"}, next_h, next_v,
                            video_hcount, video_vcount);
                check_flag({test_name, " video_active"},
                           int'(video_hcount) < H_ACTIVE && int'(video_vcount) < V_ACTIVE,
                           video_active);
            end
            h_d2 = h_d1;
            v_d2 = v_d1;
            h_d1 = video_hcount;
            v_d1 = video_vcount;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Something failed");
        $finish;
    end

    initial begin
        hcount_t cx;
        vcount_t cy;
        logic    hit;
        int      thr;
        seed_val      = $urandom(8);
        sys_rst_pixel = 1'b1;
        thresh_lower  = 8'd128;
        display_sel   = 1'b0;
        crosshair_en  = 1'b0;
        calib_start   = 1'b0;
        repeat (8) @(posedge clk_pixel);
        #2;
        sys_rst_pixel = 1'b0;

        // black outputs and idle calibration right out of reset, then one frame of timing
        begin_test("after_reset");
        check_coord({test_name, " counters"}, '0, '0, video_hcount, video_vcount);
        check_color({test_name, " red"}, '0, out_red);
        check_color({test_name, " green"}, '0, out_green);
        check_color({test_name, " blue"}, '0, out_blue);
        check_flag({test_name, " calib_busy"}, 1'b0, calib_busy);
        check_flag({test_name, " calib_done"}, 1'b0, calib_done);
        check_flag({test_name, " calib_hit"}, 1'b0, calib_hit);
        wait_frame_start();
        video_check = 1'b1;
        wait_frame_start();
        video_check = 1'b0;
        end_test();

        // mask view over a pattern that spans the byte range
        begin_test("mask_view");
        wait_frame_start();
        pattern_on = 1'b1;
        salt       = rand_between(0, 255);
        #1;
        display_sel  = 1'b1;
        thresh_lower = chroma_t'(rand_between(1, 255));
        wait_frame_start();
        video_check = 1'b1;
        wait_frame_start();
        video_check = 1'b0;
        end_test();

        // crosshair settles on the rectangle centroid one frame after a full frame
        begin_test("tracking");
        wait_frame_start();
        thr = rand_between(64, 192);
        place_rect(thr);
        #1;
        display_sel  = 1'b0;
        crosshair_en = 1'b1;
        thresh_lower = chroma_t'(thr);
        void'(ref_centroid(cx, cy));
        exp_track_x = cx;
        exp_track_y = cy;
        repeat (2) wait_frame_start();
        video_check = 1'b1;
        wait_frame_start();
        video_check = 1'b0;
        end_test();

        begin_test("calib_hit");
        wait_frame_start();
        place_rect(thr);
        #1;
        hit = ref_centroid(cx, cy);
        run_calibration(hit, cx, cy);
        exp_track_x = cx;
        exp_track_y = cy;
        end_test();

        // scene switched at a frame start so no partial frame moves the crosshair
        begin_test("calib_miss");
        wait_frame_start();
        rect_w = 0;
        run_calibration(1'b0, '0, '0);
        wait_frame_start();
        video_check = 1'b1;
        wait_frame_start();
        video_check = 1'b0;
        end_test();

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: verilog/calib_step_ctrl.sv
`timescale 1ns/1ps

module calib_step_ctrl
    import led_locator_pkg::*;
#(
    parameter int WAIT_FRAMES = 4
) (
    input  logic    clk_pixel,
    input  logic    sys_rst_pixel,
    input  logic    calib_start,
    input  logic    new_frame,
    input  logic    result_valid,
    input  logic    result_empty,
    input  hcount_t result_x,
    input  vcount_t result_y,
    output logic    calib_busy,
    output logic    calib_done,
    output logic    calib_hit,
    output hcount_t calib_x,
    output vcount_t calib_y,
    output hcount_t track_x,
    output vcount_t track_y
);

    localparam int FCNT_W = (WAIT_FRAMES > 1) ? $clog2(WAIT_FRAMES) : 1;

    calib_state_t      state;
    logic [FCNT_W-1:0] frame_cnt;
    logic              last_wait;

    // frame pulse that starts the measured frame
    assign last_wait  = (int'(frame_cnt) == WAIT_FRAMES - 1);
    // busy from the cycle after the strobe until done
    assign calib_busy = (state != IDLE);

    // the parameter hides the enum literal, so the wait state is named through the package
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            state      <= IDLE;
            frame_cnt  <= '0;
            calib_done <= 1'b0;
            calib_hit  <= 1'b0;
            calib_x    <= '0;
            calib_y    <= '0;
        end else begin
            calib_done <= 1'b0;
            case (state)
                // strobes while busy never reach this branch
                IDLE: begin
                    if (calib_start) begin
                        state     <= led_locator_pkg::WAIT_FRAMES;
                        frame_cnt <= '0;
                    end
                end
                led_locator_pkg::WAIT_FRAMES: begin
                    if (new_frame) begin
                        if (last_wait) begin
                            state <= MEASURE;
                        end else begin
                            frame_cnt <= frame_cnt + 1'b1;
                        end
                    end
                end
                // results of the frame before are skipped here
                MEASURE: begin
                    if (new_frame) begin
                        state <= REPORT;
                    end
                end
                REPORT: begin
                    if (result_valid) begin
                        state      <= IDLE;
                        calib_done <= 1'b1;
                        calib_hit  <= !result_empty;
                        calib_x    <= result_x;
                        calib_y    <= result_y;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // crosshair follows every frame that saw the led
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            track_x <= '0;
            track_y <= '0;
        end else if (result_valid && !result_empty) begin
            track_x <= result_x;
            track_y <= result_y;
        end
    end

    a_done_from_report: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
        calib_done |-> $past(state) == REPORT);

endmodule

// File: verilog/centroid_accum.sv
`timescale 1ns/1ps

module centroid_accum
    import led_locator_pkg::*;
(
    input  logic    clk_pixel,
    input  logic    sys_rst_pixel,
    input  hcount_t x,
    input  vcount_t y,
    input  logic    active,
    input  logic    new_frame,
    input  logic    mask,
    output logic    result_valid,
    output logic    result_empty,
    output hcount_t x_out,
    output vcount_t y_out
);

    // count covers every pixel of the largest frame
    localparam int CNT_W  = HCOUNT_W + VCOUNT_W;
    // sum of coordinates, both axes use the wider x width
    localparam int SUM_W  = HCOUNT_W + CNT_W;
    // shifted remainder needs one bit over the divisor
    localparam int REM_W  = CNT_W + 1;
    localparam int STEP_W = $clog2(SUM_W + 1);

    logic [SUM_W-1:0]       sum_x;
    logic [SUM_W-1:0]       sum_y;
    logic [CNT_W-1:0]       count;
    logic                   hit;
    logic                   busy;
    logic [STEP_W-1:0]      steps_left;
    logic [CNT_W-1:0]       den;
    logic [REM_W-1:0]       rem_x;
    logic [REM_W-1:0]       rem_y;
    logic [SUM_W-1:0]       quo_x;
    logic [SUM_W-1:0]       quo_y;
    logic [REM_W+SUM_W-1:0] next_x;
    logic [REM_W+SUM_W-1:0] next_y;

    // one restoring step, dividend shifts out the top while quotient bits enter below
    function automatic logic [REM_W+SUM_W-1:0] div_step(
        input logic [REM_W-1:0] rem,
        input logic [SUM_W-1:0] quo,
        input logic [CNT_W-1:0] divisor
    );
        logic [REM_W-1:0] trial;
        trial = {rem[REM_W-2:0], quo[SUM_W-1]};
        if (trial >= REM_W'(divisor)) begin
            return {trial - REM_W'(divisor), quo[SUM_W-2:0], 1'b1};
        end
        return {trial, quo[SUM_W-2:0], 1'b0};
    endfunction

    assign hit    = active && mask;
    assign next_x = div_step(rem_x, quo_x, den);
    assign next_y = div_step(rem_y, quo_y, den);

    // frame sums, the new_frame pixel already belongs to the next frame
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            sum_x <= '0;
            sum_y <= '0;
            count <= '0;
        end else if (new_frame) begin
            sum_x <= hit ? SUM_W'(x) : '0;
            sum_y <= hit ? SUM_W'(y) : '0;
            count <= hit ? CNT_W'(1) : '0;
        end else if (hit) begin
            sum_x <= sum_x + SUM_W'(x);
            sum_y <= sum_y + SUM_W'(y);
            count <= count + 1'b1;
        end
    end

    // divider sequencing, empty frame reports on the next cycle
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            busy         <= 1'b0;
            steps_left   <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (new_frame) begin
                busy         <= (count != '0);
                steps_left   <= STEP_W'(SUM_W);
                result_valid <= (count == '0);
            end else if (busy) begin
                if (steps_left == '0) begin
                    busy         <= 1'b0;
                    result_valid <= 1'b1;
                end else begin
                    steps_left <= steps_left - 1'b1;
                end
            end
        end
    end

    // both dividers share the divisor and step in lockstep
    always_ff @(posedge clk_pixel) begin
        if (new_frame) begin
            den   <= count;
            quo_x <= sum_x;
            quo_y <= sum_y;
            rem_x <= '0;
            rem_y <= '0;
        end else if (busy && steps_left != '0) begin
            {rem_x, quo_x} <= next_x;
            {rem_y, quo_y} <= next_y;
        end
    end

    // quotients fit the coordinate width since the mean stays inside the frame
    always_ff @(posedge clk_pixel) begin
        if (new_frame && count == '0) begin
            result_empty <= 1'b1;
            x_out        <= '0;
            y_out        <= '0;
        end else if (busy && steps_left == '0) begin
            result_empty <= 1'b0;
            x_out        <= quo_x[HCOUNT_W-1:0];
            y_out        <= quo_y[VCOUNT_W-1:0];
        end
    end

    // frame time must cover the whole division
    a_no_frame_while_busy: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
        new_frame |-> !busy);

endmodule

// File: verilog/chroma_threshold.sv
`timescale 1ns/1ps

module chroma_threshold
    import led_locator_pkg::*;
(
    input  logic    clk_pixel,
    input  logic    sys_rst_pixel,
    input  chroma_t pixel,
    input  chroma_t lower_bound,
    output logic    detect
);

    logic in_range;

    // inclusive window from lower_bound up to full scale
    assign in_range = (pixel >= lower_bound) && (pixel <= CHROMA_MAX);

    // one cycle of latency, detect lines up with the stage 1 coordinate
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            detect <= 1'b0;
        end else begin
            detect <= in_range;
        end
    end

endmodule

// File: verilog/led_locator_pkg.sv
package led_locator_pkg;

    // pixel coordinate widths, one word for 1280x720 timing
    localparam int HCOUNT_W = 11;
    localparam int VCOUNT_W = 10;

    // one chroma or colour byte
    localparam int CHROMA_W = 8;

    typedef logic [HCOUNT_W-1:0] hcount_t;
    typedef logic [VCOUNT_W-1:0] vcount_t;
    typedef logic [CHROMA_W-1:0] chroma_t;

    // threshold window always ends at full scale
    localparam chroma_t CHROMA_MAX = '1;

    // per-pixel timing flags, travel with the coordinate
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic active;
        logic new_frame;
    } sync_flags_t;

    // calibration step sequence
    typedef enum logic [1:0] {
        IDLE,
        WAIT_FRAMES,
        MEASURE,
        REPORT
    } calib_state_t;

endpackage

// File: verilog/led_locator_top.sv
`timescale 1ns/1ps

module led_locator_top
    import led_locator_pkg::*;
#(
    parameter int H_ACTIVE    = 1280,
    parameter int H_FRONT     = 110,
    parameter int H_SYNC      = 40,
    parameter int H_TOTAL     = 1650,
    parameter int V_ACTIVE    = 720,
    parameter int V_FRONT     = 5,
    parameter int V_SYNC      = 5,
    parameter int V_TOTAL     = 750,
    parameter int WAIT_FRAMES = 4
) (
    input  logic    clk_pixel,
    input  logic    sys_rst_pixel,
    input  chroma_t cr_in,
    input  chroma_t cb_in,
    input  chroma_t thresh_lower,
    input  logic    display_sel,
    input  logic    crosshair_en,
    input  logic    calib_start,
    output hcount_t video_hcount,
    output vcount_t video_vcount,
    output logic    video_active,
    output chroma_t out_red,
    output chroma_t out_green,
    output chroma_t out_blue,
    output logic    out_hsync,
    output logic    out_vsync,
    output logic    out_active,
    output logic    calib_busy,
    output logic    calib_done,
    output logic    calib_hit,
    output hcount_t calib_x,
    output vcount_t calib_y
);

    // coordinate bundle and chroma pair, local to the delay lines
    typedef struct packed {
        hcount_t     hcount;
        vcount_t     vcount;
        sync_flags_t flags;
    } pix_pos_t;

    typedef struct packed {
        chroma_t cr;
        chroma_t cb;
    } chroma_pair_t;

    // stage 0, straight from the timing generator
    hcount_t      hcount_s0;
    vcount_t      vcount_s0;
    sync_flags_t  flags_s0;
    pix_pos_t     pos_s0;
    chroma_pair_t chroma_s0;
    // stage 1, aligned with the threshold outputs
    pix_pos_t     pos_s1;
    chroma_pair_t chroma_s1;
    logic         detect_r;
    logic         detect_b;
    // stage 2, aligned with the overlay colour
    sync_flags_t  flags_s2;
    // centroid results and tracked position
    logic         result_valid;
    logic         result_empty;
    hcount_t      result_x;
    vcount_t      result_y;
    hcount_t      track_x;
    vcount_t      track_y;

    assign pos_s0       = '{hcount: hcount_s0, vcount: vcount_s0, flags: flags_s0};
    assign chroma_s0    = '{cr: cr_in, cb: cb_in};
    assign video_hcount = hcount_s0;
    assign video_vcount = vcount_s0;
    assign video_active = flags_s0.active;
    assign out_hsync    = flags_s2.hsync;
    assign out_vsync    = flags_s2.vsync;
    assign out_active   = flags_s2.active;

    video_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_TOTAL(H_TOTAL),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_TOTAL(V_TOTAL)
    ) u_timing (
        .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel),
        .hcount(hcount_s0), .vcount(vcount_s0), .flags(flags_s0)
    );

    // bit 0 mask from cr, bit 1 mask from cb
    chroma_threshold u_thresh_cr (
        .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel),
        .pixel(cr_in), .lower_bound(thresh_lower), .detect(detect_r)
    );

    chroma_threshold u_thresh_cb (
        .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel),
        .pixel(cb_in), .lower_bound(thresh_lower), .detect(detect_b)
    );

    pipe_delay #(.DEPTH(1), .T(pix_pos_t)) u_pos_d1 (
        .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel), .din(pos_s0), .dout(pos_s1)
    );

    pipe_delay #(.DEPTH(1), .T(chroma_pair_t)) u_chroma_d1 (
        .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel), .din(chroma_s0), .dout(chroma_s1)
    );

    pipe_delay #(.DEPTH(1), .T(sync_flags_t)) u_flags_d2 (
        .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel),
        .din(pos_s1.flags), .dout(flags_s2)
    );

    centroid_accum u_centroid (
        .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel),
        .x(pos_s1.hcount), .y(pos_s1.vcount), .active(pos_s1.flags.active),
        .new_frame(pos_s1.flags.new_frame), .mask(detect_b),
        .result_valid(result_valid), .result_empty(result_empty),
        .x_out(result_x), .y_out(result_y)
    );

    calib_step_ctrl #(.WAIT_FRAMES(WAIT_FRAMES)) u_ctrl (
        .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel),
        .calib_start(calib_start), .new_frame(pos_s1.flags.new_frame),
        .result_valid(result_valid), .result_empty(result_empty),
        .result_x(result_x), .result_y(result_y),
        .calib_busy(calib_busy), .calib_done(calib_done), .calib_hit(calib_hit),
        .calib_x(calib_x), .calib_y(calib_y), .track_x(track_x), .track_y(track_y)
    );

    overlay_mux u_overlay (
        .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel),
        .cr(chroma_s1.cr), .cb(chroma_s1.cb), .detect_r(detect_r), .detect_b(detect_b),
        .active(pos_s1.flags.active), .display_sel(display_sel), .crosshair_en(crosshair_en),
        .hcount(pos_s1.hcount), .vcount(pos_s1.vcount), .track_x(track_x), .track_y(track_y),
        .red(out_red), .green(out_green), .blue(out_blue)
    );

endmodule

// File: verilog/overlay_mux.sv
`timescale 1ns/1ps

module overlay_mux
    import led_locator_pkg::*;
(
    input  logic    clk_pixel,
    input  logic    sys_rst_pixel,
    input  chroma_t cr,
    input  chroma_t cb,
    input  logic    detect_r,
    input  logic    detect_b,
    input  logic    active,
    input  logic    display_sel,
    input  logic    crosshair_en,
    input  hcount_t hcount,
    input  vcount_t vcount,
    input  hcount_t track_x,
    input  vcount_t track_y,
    output chroma_t red,
    output chroma_t green,
    output chroma_t blue
);

    logic on_cross;

    assign on_cross = crosshair_en && ((hcount == track_x) || (vcount == track_y));

    // priority blanking, crosshair, then the selected view
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel || !active) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (on_cross) begin
            red   <= CHROMA_MAX;
            green <= CHROMA_MAX;
            blue  <= CHROMA_MAX;
        end else if (!display_sel) begin
            // chroma view
            red   <= cr;
            green <= '0;
            blue  <= cb;
        end else if (detect_b) begin
            red   <= CHROMA_MAX;
            green <= CHROMA_MAX;
            blue  <= CHROMA_MAX;
        end else begin
            // magenta marks cr only, black otherwise
            red   <= detect_r ? CHROMA_MAX : '0;
            green <= '0;
            blue  <= detect_r ? CHROMA_MAX : '0;
        end
    end

endmodule

// File: verilog/pipe_delay.sv
`timescale 1ns/1ps

module pipe_delay #(
    parameter int  DEPTH = 1,
    parameter type T     = logic
) (
    input  logic clk_pixel,
    input  logic sys_rst_pixel,
    input  T     din,
    output T     dout
);

    // register chain, stage 0 takes din
    T stage [DEPTH];

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[DEPTH-1];

endmodule

// File: verilog/video_timing.sv
`timescale 1ns/1ps

module video_timing
    import led_locator_pkg::*;
#(
    parameter int H_ACTIVE = 1280,
    parameter int H_FRONT  = 110,
    parameter int H_SYNC   = 40,
    parameter int H_TOTAL  = 1650,
    parameter int V_ACTIVE = 720,
    parameter int V_FRONT  = 5,
    parameter int V_SYNC   = 5,
    parameter int V_TOTAL  = 750
) (
    input  logic        clk_pixel,
    input  logic        sys_rst_pixel,
    output hcount_t     hcount,
    output vcount_t     vcount,
    output sync_flags_t flags
);

    // wrapping pixel and line counters
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            hcount <= '0;
            vcount <= '0;
        end else if (int'(hcount) == H_TOTAL - 1) begin
            hcount <= '0;
            // line wrap at the bottom of the frame
            if (int'(vcount) == V_TOTAL - 1) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 1'b1;
            end
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // flags decoded straight from the counters, same cycle as the coordinate
    always_comb begin
        flags.active    = (int'(hcount) < H_ACTIVE) && (int'(vcount) < V_ACTIVE);
        flags.hsync     = (int'(hcount) >= H_ACTIVE + H_FRONT) &&
                          (int'(hcount) < H_ACTIVE + H_FRONT + H_SYNC);
        flags.vsync     = (int'(vcount) >= V_ACTIVE + V_FRONT) &&
                          (int'(vcount) < V_ACTIVE + V_FRONT + V_SYNC);
        // first pixel of the frame only
        flags.new_frame = (hcount == '0) && (vcount == '0);
    end

    a_hcount_range: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
        int'(hcount) < H_TOTAL);

endmodule
